// File: Makefile
VERILATOR  ?= verilator
TOP        ?= uart_rx_tb
RTL_TOP    ?= uart_rx_top
FILELIST   ?= project.f
BUILD_DIR  ?= ./obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
verilog/uart_rx_pkg.sv
verilog/rx_byte_if.sv
verilog/rx_line_sync.sv
verilog/uart_rx.sv
verilog/rx_byte_fifo.sv
verilog/rx_host_port.sv
verilog/uart_rx_top.sv
verification/uart_rx_assert.sv
verification/uart_rx_tb.sv

// File: verification/uart_rx_assert.sv
`timescale 1ns/1ns

module uart_rx_assert (
    input logic               clk,
    input logic               reset,
    input logic               host_ack,
    input logic               host_req,
    input uart_rx_pkg::byte_t host_data,
    input logic               host_frame_err
);

    //////////////////////////////
    // Four-phase handshake rules
    //////////////////////////////

    // Req is held until the host answers with ack
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset) host_req && !host_ack |=> host_req
    ) else $error("host_req fell while host_ack was low");

    // The offered word does not move under an open request
    data_stable_under_req: assert property (
        @(posedge clk) disable iff (reset)
        host_req |=> !host_req || ($stable(host_data) && $stable(host_frame_err))
    ) else $error("host_data or host_frame_err changed while host_req was high");

    // A new request waits until the previous ack has dropped
    no_req_while_ack: assert property (
        @(posedge clk) disable iff (reset) host_ack && !host_req |=> !host_req
    ) else $error("host_req rose while host_ack was still high");

endmodule

bind rx_host_port uart_rx_assert u_handshake_assert (
    .clk            (clk),
    .reset          (reset),
    .host_ack       (host_ack),
    .host_req       (host_req),
    .host_data      (host_data),
    .host_frame_err (host_frame_err)
);

// File: verification/uart_rx_tb.sv
`timescale 1ns/1ns

module uart_rx_tb;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 8;
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT; // Start bit, eight data bits and stop bit
    localparam int REQ_TIMEOUT  = 4 * FRAME_CLKS;    // Longest wait for host_req to rise
    localparam int ACK_TIMEOUT  = 16;                // Req drops one cycle after ack

    logic               clk;
    logic               reset;
    logic               rx;
    logic               host_ack;
    logic               host_req;
    uart_rx_pkg::byte_t host_data;
    logic               host_frame_err;
    logic               overrun;

    uart_rx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    //////////////////////////////
    // Checking helpers
    //////////////////////////////

    task automatic check_value(input string test_name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("tests failed");
            $fatal(1, "%s stopped on a wrong %s", test_name, what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("tests failed");
        $fatal(1, "Wait loop timed out");
    endtask

    //////////////////////////////
    // Serial line and host side
    //////////////////////////////

    task automatic drive_bit(input logic level);
        rx <= level;
        repeat (CLKS_PER_BIT) @(posedge clk); // One full bit-time on the line
    endtask

    // One 8N1 frame with the data LSB first and a low stop bit when bad_stop is set
    task automatic send_frame(input uart_rx_pkg::byte_t data, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < uart_rx_pkg::DATA_BITS; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(!bad_stop);
    endtask

    task automatic wait_for_req();
        int cycles;
        cycles = 0;
        while (!host_req) begin
            if (cycles == REQ_TIMEOUT) begin
                report_timeout("host_req to rise");
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    // Full four-phase handshake that returns the word offered under req
    task automatic host_read(output uart_rx_pkg::byte_t data, output logic frame_err);
        int cycles;
        wait_for_req();
        data      = host_data;
        frame_err = host_frame_err;
        host_ack <= 1'b1;
        cycles = 0;
        while (host_req) begin
            if (cycles == ACK_TIMEOUT) begin
                report_timeout("host_req to fall after host_ack");
            end
            @(posedge clk);
            cycles++;
        end
        host_ack <= 1'b0;
        @(posedge clk); // Port sees ack low and rearms
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_after_reset();
        check_value("after_reset", "host_req", 0, int'(host_req));
        check_value("after_reset", "overrun", 0, int'(overrun));
        check_value("after_reset", "framer state", int'(uart_rx_pkg::IDLE),
                    int'(UUT.u_framer.state));
    endtask

    task automatic test_single_byte();
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        send_frame(8'hA5, 1'b0);
        host_read(data, frame_err);
        check_value("single_byte", "data", 'hA5, int'(data));
        check_value("single_byte", "frame_err", 0, int'(frame_err));
        check_value("single_byte", "overrun", 0, int'(overrun));
    endtask

    task automatic test_burst();
        uart_rx_pkg::byte_t sent [FIFO_DEPTH];
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            sent[i] = 8'($urandom);
            send_frame(sent[i], 1'b0); // No idle time between frames
        end
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            host_read(data, frame_err);
            check_value("burst", "data", int'(sent[i]), int'(data));
            check_value("burst", "frame_err", 0, int'(frame_err));
        end
        check_value("burst", "overrun", 0, int'(overrun));
    endtask

    task automatic test_frame_error();
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        send_frame(8'h3C, 1'b1);
        drive_bit(1'b1); // Line back to idle so the framer rearms
        drive_bit(1'b1);
        send_frame(8'hC3, 1'b0);
        host_read(data, frame_err);
        check_value("frame_error", "bad frame data", 'h3C, int'(data));
        check_value("frame_error", "bad frame frame_err", 1, int'(frame_err));
        host_read(data, frame_err);
        check_value("frame_error", "good frame data", 'hC3, int'(data));
        check_value("frame_error", "good frame frame_err", 0, int'(frame_err));
    endtask

    task automatic test_false_start();
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        rx <= 1'b0; // Single-clock glitch that the filter removes
        @(posedge clk);
        rx <= 1'b1;
        repeat (CLKS_PER_BIT) begin
            @(posedge clk);
            // The framer never sees the glitch, so it stays armed in IDLE
            check_value("false_start", "framer state after glitch", int'(uart_rx_pkg::IDLE),
                        int'(UUT.u_framer.state));
        end
        rx <= 1'b0; // Quarter bit passes the filter but fails the start check
        repeat (CLKS_PER_BIT / 4) @(posedge clk);
        rx <= 1'b1;
        repeat (2 * FRAME_CLKS) begin
            @(posedge clk);
            check_value("false_start", "host_req", 0, int'(host_req));
        end
        send_frame(8'h5A, 1'b0);
        host_read(data, frame_err);
        check_value("false_start", "data", 'h5A, int'(data));
        check_value("false_start", "frame_err", 0, int'(frame_err));
    endtask

    task automatic test_slow_host();
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        send_frame(8'h96, 1'b0);
        wait_for_req();
        check_value("slow_host", "offered data", 'h96, int'(host_data));
        repeat (8 * CLKS_PER_BIT) begin // Host sits on the request
            @(posedge clk);
            check_value("slow_host", "host_req", 1, int'(host_req));
            check_value("slow_host", "host_data", 'h96, int'(host_data));
            check_value("slow_host", "host_frame_err", 0, int'(host_frame_err));
        end
        host_read(data, frame_err);
        check_value("slow_host", "data", 'h96, int'(data));
        check_value("slow_host", "frame_err", 0, int'(frame_err));
        check_value("slow_host", "host_req after ack", 0, int'(host_req));
    endtask

    task automatic test_overrun();
        uart_rx_pkg::byte_t sent [FIFO_DEPTH+3];
        uart_rx_pkg::byte_t data;
        logic               frame_err;
        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            sent[i] = 8'($urandom);
            send_frame(sent[i], 1'b0);
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        check_value("overrun", "overrun", 1, int'(overrun));
        // One byte sits in the host port and the FIFO holds the next FIFO_DEPTH
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            host_read(data, frame_err);
            check_value("overrun", "data", int'(sent[i]), int'(data));
            check_value("overrun", "frame_err", 0, int'(frame_err));
        end
        repeat (FRAME_CLKS) begin
            @(posedge clk);
            check_value("overrun", "host_req when drained", 0, int'(host_req));
        end
    endtask

    initial begin
        void'($urandom(80));
        reset       = 1'b1;
        rx          = 1'b1; // Idle line level
        host_ack    = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_after_reset();
        test_single_byte();
        test_burst();
        test_frame_error();
        test_false_start();
        test_slow_host();
        test_overrun(); // Runs last because overrun stays set until reset
        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/rx_byte_fifo.sv
`timescale 1ns/1ns

module rx_byte_fifo #(
    parameter int FIFO_DEPTH = 8 // Power of two so the pointers wrap on their own
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  uart_rx_pkg::byte_t push_data,
    input  logic               push_frame_err,
    rx_byte_if.source          out,
    output logic               overrun
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    uart_rx_pkg::rx_word_t mem [FIFO_DEPTH];
    uart_rx_pkg::rx_word_t rd_word;   // Entry at the head of the queue
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W:0]        count;     // One bit wider so that full is representable
    logic                  full;
    logic                  pop;
    logic                  push_ok;   // Push that actually lands in the buffer

    assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign pop     = out.valid && out.ready;
    // A pop in the same cycle frees the slot that the push fills
    assign push_ok = push && (!full || pop);

    // Head entry drives the stream whenever something is stored
    assign rd_word       = mem[rd_ptr];
    assign out.valid     = (count != '0);
    assign out.data      = rd_word[uart_rx_pkg::DATA_BITS-1:0];
    assign out.frame_err = rd_word[uart_rx_pkg::DATA_BITS];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= {push_frame_err, push_data}; // Flag above the byte
        end
    end

    //////////////////////////////
    // Pointers and flags
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither leave the fill level
            endcase

            // The framer cannot be stalled, so a lost byte is only flagged
            if (push && !push_ok) begin
                overrun <= 1'b1; // Sticky until reset
            end
        end
    end

endmodule

// File: verilog/rx_byte_if.sv
`timescale 1ns/1ns

// Byte stream between the FIFO and the host port.
// A word moves on a cycle where valid and ready are both high,
// and data and frame_err do not change while valid is high
interface rx_byte_if;

    uart_rx_pkg::byte_t data;      // Received byte
    logic               frame_err; // Stop bit was low for this byte
    logic               valid;     // Source holds a word
    logic               ready;     // Sink takes the word this cycle

    // Side that owns the words
    modport source (
        output data,
        output frame_err,
        output valid,
        input  ready
    );

    // Side that consumes the words
    modport sink (
        input  data,
        input  frame_err,
        input  valid,
        output ready
    );

endinterface

// File: verilog/rx_host_port.sv
`timescale 1ns/1ns

module rx_host_port (
    input  logic               clk,
    input  logic               reset,
    rx_byte_if.sink            in,
    input  logic               host_ack,
    output logic               host_req,
    output uart_rx_pkg::byte_t host_data,
    output logic               host_frame_err
);

    //////////////////////////////
    // Handshake phases
    //////////////////////////////

    typedef enum logic [1:0] {
        WAIT_WORD = 2'd0, // Nothing offered, look for a FIFO word
        REQ_HIGH  = 2'd1, // Word offered, waiting for the host to ack
        ACK_LOW   = 2'd2  // Req dropped, waiting for the host to release ack
    } phase_t;

    phase_t phase;

    // Take a word only when the previous handshake has fully closed
    assign in.ready = (phase == WAIT_WORD) && !host_ack;

    assign host_req = (phase == REQ_HIGH); // Rises the cycle after the pop

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= WAIT_WORD;
        end else begin
            case (phase)
                WAIT_WORD: begin
                    if (in.valid && in.ready) begin
                        phase <= REQ_HIGH;
                    end
                end
                REQ_HIGH: begin
                    if (host_ack) begin
                        phase <= ACK_LOW; // Req falls one cycle after ack
                    end
                end
                ACK_LOW: begin
                    if (!host_ack) begin
                        phase <= WAIT_WORD;
                    end
                end
                default: begin
                    phase <= WAIT_WORD;
                end
            endcase
        end
    end

    // Holding register, loaded on the pop and frozen for the whole handshake,
    // so the FIFO keeps filling while a slow host looks at this word
    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            host_data      <= in.data;
            host_frame_err <= in.frame_err;
        end
    end

endmodule

// File: verilog/rx_line_sync.sv
`timescale 1ns/1ns

module rx_line_sync (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic rx_clean
);

    //////////////////////////////
    // Synchronizer and history
    //////////////////////////////

    logic [1:0] sync_ff;  // Two-flop chain, bit 1 is the usable copy
    logic [1:0] hist;     // The two synchronized samples before sync_ff[1]
    logic       majority; // Vote over the last three samples

    // Two of three wins, so a level must hold for two samples to pass
    assign majority = (sync_ff[1] & hist[0]) |
                      (sync_ff[1] & hist[1]) |
                      (hist[0] & hist[1]);

    // A change on rx reaches sync_ff[1] after two edges, hist[0] after three,
    // and the registered vote flips on the fourth edge
    always_ff @(posedge clk) begin
        if (reset) begin
            // The serial line idles high, so everything starts at 1
            sync_ff  <= 2'b11;
            hist     <= 2'b11;
            rx_clean <= 1'b1;
        end else begin
            sync_ff  <= {sync_ff[0], rx};     // Shift the asynchronous line in
            hist     <= {hist[0], sync_ff[1]}; // Age the synchronized samples
            rx_clean <= majority;              // One-cycle glitches lose the vote
        end
    end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx_clean,
    output logic               byte_valid,
    output uart_rx_pkg::byte_t byte_data,
    output logic               byte_frame_err
);

    //////////////////////////////
    // Counter sizing
    //////////////////////////////

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(uart_rx_pkg::DATA_BITS);

    // Last count of the half bit before the start check
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    // Last count of a full bit, the next sample point
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    // Index of the final data bit
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(uart_rx_pkg::DATA_BITS - 1);

    uart_rx_pkg::rx_state_t state;
    logic [CNT_W-1:0]       clk_cnt;   // Clocks since the last sample point
    logic [IDX_W-1:0]       bit_idx;   // Data bit being sampled next
    uart_rx_pkg::byte_t     shift_reg; // Fills from the top, so the LSB lands in bit 0
    logic                   wait_high; // Stop bit was low, hold off until the line idles

    assign byte_data = shift_reg; // Stays put until the next frame starts shifting

    //////////////////////////////
    // Framer FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= uart_rx_pkg::IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            wait_high  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0; // Only ever a single-cycle pulse

            case (state)
                uart_rx_pkg::IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // IDLE is only entered with the line high, so a low level
                    // here is the falling edge of a start bit
                    if (!rx_clean) begin
                        state <= uart_rx_pkg::START;
                    end
                end

                uart_rx_pkg::START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        // Middle of the start bit, a high line means a false start
                        if (rx_clean) begin
                            state <= uart_rx_pkg::IDLE;
                        end else begin
                            state <= uart_rx_pkg::DATA;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                uart_rx_pkg::DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt   <= '0;
                        shift_reg <= {rx_clean, shift_reg[uart_rx_pkg::DATA_BITS-1:1]};
                        if (bit_idx == IDX_LAST) begin
                            bit_idx <= '0;
                            state   <= uart_rx_pkg::STOP; // Stop bit one bit-time on
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                uart_rx_pkg::STOP: begin
                    if (wait_high) begin
                        // Line held low after a bad frame, rearm once it idles
                        if (rx_clean) begin
                            wait_high <= 1'b0;
                            state     <= uart_rx_pkg::IDLE;
                        end
                    end else if (clk_cnt == BIT_LAST) begin
                        clk_cnt        <= '0;
                        byte_valid     <= 1'b1;
                        byte_frame_err <= !rx_clean; // Low stop bit is a framing error
                        if (rx_clean) begin
                            state <= uart_rx_pkg::IDLE;
                        end else begin
                            wait_high <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= uart_rx_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/uart_rx_pkg.sv
package uart_rx_pkg;

    //////////////////////////////
    // Frame format
    //////////////////////////////

    // Data bits in one 8N1 frame, sent LSB first
    localparam int DATA_BITS = 8;

    //////////////////////////////
    // Payload types
    //////////////////////////////

    // One received data byte
    typedef logic [DATA_BITS-1:0] byte_t;

    // One FIFO entry. The frame error flag sits above the byte
    // so that bit DATA_BITS is the flag and the low bits are the data
    typedef logic [DATA_BITS:0] rx_word_t;

    //////////////////////////////
    // Framer states
    //////////////////////////////

    // IDLE waits for the line to fall, START checks the start bit at mid-bit,
    // DATA shifts in the data bits and STOP checks the stop bit
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } rx_state_t;

endpackage

// File: verilog/uart_rx_top.sv
`timescale 1ns/1ns

module uart_rx_top #(
    parameter int CLKS_PER_BIT = 16, // Clocks per serial bit
    parameter int FIFO_DEPTH   = 8   // Received bytes buffered ahead of the host
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx,
    input  logic               host_ack,
    output logic               host_req,
    output uart_rx_pkg::byte_t host_data,
    output logic               host_frame_err,
    output logic               overrun
);

    //////////////////////////////
    // Internal links
    //////////////////////////////

    logic               rx_clean;       // Filtered serial line
    logic               byte_valid;     // One-cycle pulse per received frame
    uart_rx_pkg::byte_t byte_data;
    logic               byte_frame_err;

    rx_byte_if fifo_out (); // FIFO head towards the host port

    //////////////////////////////
    // Receive chain
    //////////////////////////////

    // Line cleanup ahead of the framer
    rx_line_sync u_line_sync (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_clean (rx_clean)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_framer (
        .clk            (clk),
        .reset          (reset),
        .rx_clean       (rx_clean),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .byte_frame_err (byte_frame_err)
    );

    // No ready back to the framer, a full FIFO drops and flags
    rx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .reset          (reset),
        .push           (byte_valid),
        .push_data      (byte_data),
        .push_frame_err (byte_frame_err),
        .out            (fifo_out.source),
        .overrun        (overrun)
    );

    rx_host_port u_host_port (
        .clk            (clk),
        .reset          (reset),
        .in             (fifo_out.sink),
        .host_ack       (host_ack),
        .host_req       (host_req),
        .host_data      (host_data),
        .host_frame_err (host_frame_err)
    );

endmodule
